/* verilog.f */
logic/enc_pkg.sv
logic/quad_decoder.sv
logic/sample_timer.sv
logic/pos_cntr.sv
logic/enc_ctrl.sv
logic/enc_top.sv
testbench/enc_tb.sv

/* run.sh */
#!/bin/sh
# build and run the encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module enc_tb -f verilog.f -o enc_sim

# exit status is nonzero when the testbench ends in $fatal
./obj_dir/enc_sim

/* testbench/enc_tb.sv */
`timescale 1ns/1ps

module enc_tb;
	import enc_pkg::*;

	logic             clk;
	logic             reset;
	logic             enc_a;
	logic             enc_b;
	logic             cmd_valid;
	enc_cmd_t         cmd_op;
	logic [per_w-1:0] cmd_data;
	logic [pos_w-1:0] pos;
	logic [cnt_w-1:0] vel;
	logic             sample_valid;
	logic             running;
	logic             enc_error;

	integer seed = 32'he73e6ab3;
	int     phase_idx = 0;	// position in the gray cycle
	int     pending = 0;	// net steps since last sample
	int     windows[$];	// net steps per finished window
	bit     samples_allowed = 0;	// sample_valid legal only after start
	int     gap;
	logic [per_w-1:0] new_per;

	enc_top i_enc_top
	(
		.clk          (clk),
		.reset        (reset),
		.enc_a        (enc_a),
		.enc_b        (enc_b),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_data     (cmd_data),
		.pos          (pos),
		.vel          (vel),
		.sample_valid (sample_valid),
		.running      (running),
		.enc_error    (enc_error)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns
	end

	//------------------------------------------------------------
	// reference model and checks
	//------------------------------------------------------------
	// last window gives vel, sum of sign-extended windows gives pos
	function automatic logic [pos_w-1:0] expected_pos(input int steps[$],
		output logic [cnt_w-1:0] last_vel);
		logic [pos_w-1:0] acc;
		logic [cnt_w-1:0] v;
		acc = '0;
		v   = '0;
		foreach (steps[i])
		begin
			v   = cnt_w'(steps[i]);	// wrap to 16 bits
			acc = acc + {{(pos_w-cnt_w){v[cnt_w-1]}}, v};
		end
		last_vel = v;
		return acc;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_pos(input logic [pos_w-1:0] got, input logic [pos_w-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t: pos is %h, expected %h", $time, got, exp));
	endtask

	task automatic check_vel(input logic [cnt_w-1:0] got, input logic [cnt_w-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t: vel is %h, expected %h", $time, got, exp));
	endtask

	task automatic check_period(input logic [per_w-1:0] got, input logic [per_w-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t: sample gap is %0d, expected %0d",
				$time, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// monitor, compares at every sample_valid on the quiet edge
	initial
	begin
		logic [pos_w-1:0] exp_pos;
		logic [cnt_w-1:0] exp_vel;
		forever
		begin
			@(negedge clk);
			if (sample_valid)
			begin
				if (!samples_allowed)
					abort_run("sample_valid seen while sampling was not enabled");
				windows.push_back(pending);
				pending = 0;
				exp_pos = expected_pos(windows, exp_vel);
				check_vel(vel, exp_vel);
				check_pos(pos, exp_pos);
			end
		end
	end

	//------------------------------------------------------------
	// stimulus helpers
	//------------------------------------------------------------
	function automatic logic [1:0] gray_phase(input int idx);
		case (idx & 3)
			0: return 2'b00;
			1: return 2'b10;	// a rises first going forward
			2: return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic send_cmd(input enc_cmd_t op, input logic [per_w-1:0] data);
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_data  = data;
		@(negedge clk);
		cmd_valid = 1'b0;	// acted on at the edge between
	endtask

	task automatic wait_sample(input int limit);
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > limit)
				abort_run("timeout waiting for sample_valid");
		end
		while (!sample_valid);
	endtask

	// wait for a window start, then n steps two clocks apart
	task automatic burst_window(input bit fwd);
		int n;
		wait_sample(400);
		@(negedge clk);
		n = ($random(seed) & 31) + 1;
		repeat (n)
		begin
			phase_idx = phase_idx + (fwd ? 1 : 3);
			{enc_a, enc_b} = gray_phase(phase_idx);
			pending = pending + (fwd ? 1 : -1);
			idle(2);
		end
	endtask

	//------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------
	initial
	begin
		reset     = 1'b1;
		enc_a     = 1'b0;
		enc_b     = 1'b0;
		cmd_valid = 1'b0;
		cmd_op    = cmd_start;
		cmd_data  = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// idle after reset, no samples for three default periods
		check_pos(pos, '0);
		check_vel(vel, '0);
		check_flag(running, 1'b0, "running");
		check_flag(sample_valid, 1'b0, "sample_valid");
		check_flag(enc_error, 1'b0, "enc_error");
		idle(300);

		send_cmd(cmd_start, '0);
		samples_allowed = 1;
		check_flag(running, 1'b1, "running");
		repeat (4) burst_window(1'b1);	// forward windows
		repeat (4) burst_window(1'b0);	// reverse windows
		wait_sample(400);	// last reverse window checked here

		// both phases at once, error but no count
		@(negedge clk);
		phase_idx = phase_idx + 2;
		{enc_a, enc_b} = gray_phase(phase_idx);
		idle(8);
		check_flag(enc_error, 1'b1, "enc_error");
		burst_window(1'b1);	// error window checked first, zero vel there
		wait_sample(400);	// vel nonzero going into the clear

		send_cmd(cmd_stop, '0);
		check_flag(running, 1'b0, "running");
		idle(3);
		samples_allowed = 0;
		send_cmd(cmd_clear, '0);
		pending = 0;
		windows.delete();
		idle(3);
		check_flag(enc_error, 1'b0, "enc_error");
		check_pos(pos, '0);
		check_vel(vel, '0);

		// short random period, gaps counted edge to edge
		new_per = per_w'(($random(seed) & 7) + 2);
		send_cmd(cmd_set_period, new_per);
		send_cmd(cmd_start, '0);
		samples_allowed = 1;
		wait_sample(400);
		repeat (3)
		begin
			gap = 0;
			do
			begin
				@(negedge clk);
				gap++;
				if (gap > 400)
					abort_run("timeout measuring the sample period");
			end
			while (!sample_valid);
			check_period(per_w'(gap), new_per);
		end

		send_cmd(cmd_stop, '0);
		check_flag(running, 1'b0, "running");
		idle(3);
		samples_allowed = 0;
		idle(5 * new_per);	// monitor flags any stray sample
		check_flag(running, 1'b0, "running");

		$display("Finished with no errors");
		$finish;
	end

endmodule

/* logic/enc_top.sv */
`timescale 1ns/1ps

module enc_top
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    enc_a,
	input  logic                    enc_b,
	input  logic                    cmd_valid,
	input  enc_pkg::enc_cmd_t       cmd_op,
	input  logic [enc_pkg::per_w-1:0] cmd_data,
	output logic [enc_pkg::pos_w-1:0] pos,
	output logic [enc_pkg::cnt_w-1:0] vel,
	output logic                    sample_valid,
	output logic                    running,
	output logic                    enc_error
);
	import enc_pkg::*;

	logic             timer_en;	// sampling enabled
	logic [per_w-1:0] period;
	logic             clear;	// zeroes datapath and error flag
	logic             sample;
	logic             cnt_en;	// one step seen
	logic             dir;	// high for a leads b

	//------------------------------------------------------------
	// control
	//------------------------------------------------------------
	enc_ctrl i_enc_ctrl
	(
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_data  (cmd_data),
		.timer_en  (timer_en),
		.clear     (clear),
		.running   (running),
		.period    (period)
	);

	sample_timer i_sample_timer
	(
		.clk      (clk),
		.reset    (reset),
		.timer_en (timer_en),
		.period   (period),
		.sample   (sample)
	);

	//------------------------------------------------------------
	// datapath
	//------------------------------------------------------------
	quad_decoder i_quad_decoder
	(
		.clk       (clk),
		.reset     (reset),
		.enc_a     (enc_a),
		.enc_b     (enc_b),
		.clr_error (clear),	// cmd_clear also drops the error
		.cnt_en    (cnt_en),
		.dir       (dir),
		.enc_error (enc_error)
	);

	pos_cntr i_pos_cntr
	(
		.clk          (clk),
		.reset        (reset),
		.cnt_en       (cnt_en),
		.dir          (dir),
		.sample       (sample),
		.clear        (clear),
		.pos          (pos),
		.vel          (vel),
		.sample_valid (sample_valid)
	);

endmodule

/* logic/enc_ctrl.sv */
`timescale 1ns/1ps

module enc_ctrl
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cmd_valid,
	input  enc_pkg::enc_cmd_t       cmd_op,
	input  logic [enc_pkg::per_w-1:0] cmd_data,
	output logic                    timer_en,
	output logic                    clear,
	output logic                    running,
	output logic [enc_pkg::per_w-1:0] period
);
	import enc_pkg::*;

	ctrl_state_t state;

	//------------------------------------------------------------
	// command decode, acts on the edge after cmd_valid
	//------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state  <= st_idle;
			clear  <= 1'b0;
			period <= default_period;
		end
		else
		begin
			clear <= 1'b0;	// single cycle pulse
			if (cmd_valid)
			begin
				case (cmd_op)
					cmd_start:
						state <= st_run;
					cmd_stop:
						state <= st_idle;
					cmd_clear:
						clear <= 1'b1;	// state untouched
					cmd_set_period:
						period <= cmd_data;	// timer treats zero as one
					default: ;
				endcase
			end
		end
	end

	// timer follows state directly, same cycle as running
	assign timer_en = (state == st_run);
	assign running  = (state == st_run);

	// timer must never be left running with a zero period
	a_period_nonzero: assert property (@(posedge clk) disable iff (reset)
		state == st_run |-> period != '0)
		else $error("zero period while running");

endmodule

/* logic/pos_cntr.sv */
`timescale 1ns/1ps

module pos_cntr
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cnt_en,
	input  logic                    dir,
	input  logic                    sample,
	input  logic                    clear,
	output logic [enc_pkg::pos_w-1:0] pos,
	output logic [enc_pkg::cnt_w-1:0] vel,
	output logic                    sample_valid
);
	import enc_pkg::*;

	logic [cnt_w-1:0] counter;	// raw step count, wraps
	logic [cnt_w-1:0] vreg1;	// count at latest sample
	logic [cnt_w-1:0] vreg2;	// count at sample before
	logic [cnt_w-1:0] win_steps;	// steps since latest sample, next vel
	logic [pos_w-1:0] velext;
	logic doadd;	// sample delayed one clock, marks the new pos

	//------------------------------------------------------------
	// up/down step counter
	//------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			counter <= '0;
		else if (clear)
			counter <= '0;
		else if (cnt_en)
			counter <= dir ? counter + 1'b1 : counter - 1'b1;
	end

	// sample delay pair, difference is steps per window
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			vreg1 <= '0;
			vreg2 <= '0;
		end
		else if (clear)
		begin
			vreg1 <= '0;
			vreg2 <= '0;
		end
		else if (sample)
		begin
			vreg2 <= vreg1;
			vreg1 <= counter;
		end
	end

	assign vel       = vreg1 - vreg2;	// wraps to signed 16 bits
	assign win_steps = counter - vreg1;	// what vel becomes at the sample edge
	assign velext    = {{(pos_w-cnt_w){win_steps[cnt_w-1]}}, win_steps};

	//------------------------------------------------------------
	// 32-bit accumulator, adds on the sample edge
	//------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			doadd <= 1'b0;
		else
			doadd <= sample;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pos <= '0;
		else if (clear)
			pos <= '0;	// clear beats a pending add
		else if (sample)
			pos <= pos + velext;	// lands together with the new vel
	end

	assign sample_valid = doadd;	// lines up with new pos

	// no add may slip through on a clear cycle
	a_clear_no_add: assert property (@(posedge clk) disable iff (reset)
		clear |=> pos == '0)
		else $error("accumulator added during clear");

endmodule

/* logic/sample_timer.sv */
`timescale 1ns/1ps

module sample_timer
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    timer_en,
	input  logic [enc_pkg::per_w-1:0] period,
	output logic                    sample
);
	import enc_pkg::*;

	logic [per_w-1:0] eff_per;	// period with zero mapped to one
	logic [per_w-1:0] cnt;	// clocks left to terminal count

	assign eff_per = (period == '0) ? per_w'(1) : period;

	//------------------------------------------------------------
	// down counter, reload at zero or while disabled
	//------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cnt <= '0;
		else if (!timer_en || cnt == '0)
			cnt <= eff_per - 1'b1;	// new period picked up here
		else
			cnt <= cnt - 1'b1;
	end

	// first pulse lands period cycles after enable rises
	assign sample = timer_en && (cnt == '0);

	// back-to-back pulses only when the reloaded period was one
	a_sample_spacing: assert property (@(posedge clk) disable iff (reset)
		sample ##1 sample |-> $past(eff_per) == per_w'(1))
		else $error("sample pulses too close for programmed period");

endmodule

/* logic/quad_decoder.sv */
`timescale 1ns/1ps

module quad_decoder
(
	input  logic clk,
	input  logic reset,
	input  logic enc_a,
	input  logic enc_b,
	input  logic clr_error,
	output logic cnt_en,
	output logic dir,
	output logic enc_error
);
	logic [1:0] sync1;	// {a,b} first sync stage
	logic [1:0] sync2;	// {a,b} safe to use
	logic [1:0] prev;	// phase pair one cycle back
	logic [1:0] fill;	// counts edges until prev holds real data
	logic armed;
	logic step;
	logic fwd;
	logic bad;

	//------------------------------------------------------------
	// two-flop synchronizer and previous-state register
	//------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			sync1 <= 2'b00;
			sync2 <= 2'b00;
			prev  <= 2'b00;
			fill  <= 2'd0;
		end
		else
		begin
			sync1 <= {enc_a, enc_b};
			sync2 <= sync1;
			prev  <= sync2;
			if (fill != 2'd3)
				fill <= fill + 2'd1;	// saturates at 3
		end
	end

	// ignore reset values of the pipe, phases may idle anywhere
	assign armed = (fill == 2'd3);

	// gray-code table on {prev, now}
	always_comb
	begin
		step = 1'b0;
		fwd  = 1'b0;
		bad  = 1'b0;
		case ({prev, sync2})
			4'b0010, 4'b1011, 4'b1101, 4'b0100:	// a leads b
			begin
				step = 1'b1;
				fwd  = 1'b1;
			end
			4'b0001, 4'b0111, 4'b1110, 4'b1000:	// b leads a
				step = 1'b1;
			4'b0011, 4'b1100, 4'b0110, 4'b1001:	// both phases moved
				bad = 1'b1;
			default: ;	// no change
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt_en    <= 1'b0;
			dir       <= 1'b0;
			enc_error <= 1'b0;
		end
		else
		begin
			cnt_en <= armed & step;
			if (armed & step)
				dir <= fwd;	// hold last direction between steps
			if (clr_error)
				enc_error <= 1'b0;
			else if (armed & bad)
				enc_error <= 1'b1;	// sticky until clear
		end
	end

	// a count strobe must come from an actual phase change
	a_step_needs_change: assert property (@(posedge clk) disable iff (reset)
		cnt_en |-> $past(sync2 != prev))
		else $error("cnt_en without phase change");

endmodule

/* logic/enc_pkg.sv */
package enc_pkg;

	//------------------------------------------------------------
	// datapath widths
	//------------------------------------------------------------
	localparam int cnt_w = 16;	// step counter and velocity
	localparam int pos_w = 32;	// position accumulator
	localparam int per_w = 16;	// sample period in clocks

	// period loaded at reset
	localparam logic [per_w-1:0] default_period = 16'd100;

	//------------------------------------------------------------
	// command port opcodes
	//------------------------------------------------------------
	typedef enum logic [1:0]
	{
		cmd_start      = 2'd0,	// enable sampling
		cmd_stop       = 2'd1,	// halt sampling
		cmd_clear      = 2'd2,	// zero position, velocity, error
		cmd_set_period = 2'd3	// load period from cmd_data
	} enc_cmd_t;

	// run/stop control states
	typedef enum logic
	{
		st_idle = 1'b0,
		st_run  = 1'b1
	} ctrl_state_t;

endpackage
